/* logic/soc_params.svh */
`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bus widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define ADDR_W 16
`define DATA_W 32

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Address map, 256 bytes per region
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define CLINT_BASE 16'h0000
`define PLIC_BASE  16'h0100
`define UART_BASE  16'h0200

`define IRQ_NUM    2 // UART and external line.
`define RST_STAGES 3

`endif

/* logic/soc_pkg.sv */
`include "soc_params.svh"

package soc_pkg;

    typedef logic [`ADDR_W-1:0]   addr_t;
    typedef logic [`DATA_W-1:0]   data_t;
    typedef logic [`DATA_W/8-1:0] sel_t;
    typedef logic [7:0]           reg_off_t; // Offset inside a region.

    typedef logic [`IRQ_NUM-1:0]  irq_vec_t;
    typedef logic [1:0]           irq_id_t;  // Zero means no source.

    typedef logic [15:0]          baud_div_t;

    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} uart_tx_state_e;
    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} uart_rx_state_e;

endpackage

/* logic/wb_if.sv */
`timescale 1ns/100ps

interface wb_if;
    import soc_pkg::*;

    logic     cyc;
    logic     stb;
    logic     we;
    reg_off_t adr;
    data_t    dat_w;
    sel_t     sel;
    data_t    dat_r;
    logic     ack;

    modport master (
        output cyc, stb, we, adr, dat_w, sel,
        input  dat_r, ack
    );

    modport slave (
        input  cyc, stb, we, adr, dat_w, sel,
        output dat_r, ack
    );
endinterface

/* logic/rst_sync.sv */
`timescale 1ns/100ps
`include "soc_params.svh"

module rst_sync #(
    parameter int STAGES = `RST_STAGES
) (
    input  logic clk,
    input  logic rst_n_i,
    output logic rst_n_o
);
    logic [STAGES-1:0] chain;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            chain <= '0; // Assert at once.
        end else begin
            chain <= {chain[STAGES-2:0], 1'b1}; // Release on the clock.
        end
    end

    assign rst_n_o = chain[STAGES-1];
endmodule

/* logic/wb_decoder.sv */
`timescale 1ns/100ps
`include "soc_params.svh"

module wb_decoder (
    input  logic           clk,
    input  logic           rst_n_i,
    input  logic           wb_cyc_i,
    input  logic           wb_stb_i,
    input  logic           wb_we_i,
    input  soc_pkg::addr_t wb_adr_i,
    input  soc_pkg::data_t wb_dat_i,
    input  soc_pkg::sel_t  wb_sel_i,
    output soc_pkg::data_t wb_dat_o,
    output logic           wb_ack_o,
    output logic           wb_err_o,
    wb_if.master           clint_bus,
    wb_if.master           plic_bus,
    wb_if.master           uart_bus
);
    import soc_pkg::*;

    addr_t region;
    logic  hit_clint, hit_plic, hit_uart;
    logic  unmapped;
    logic  err_q;

    assign region    = {wb_adr_i[`ADDR_W-1:8], 8'h00};
    assign hit_clint = (region == `CLINT_BASE);
    assign hit_plic  = (region == `PLIC_BASE);
    assign hit_uart  = (region == `UART_BASE);
    assign unmapped  = !(hit_clint || hit_plic || hit_uart);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Request fan-out
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign clint_bus.cyc   = wb_cyc_i;
    assign clint_bus.stb   = wb_stb_i & hit_clint;
    assign clint_bus.we    = wb_we_i;
    assign clint_bus.adr   = wb_adr_i[7:0];
    assign clint_bus.dat_w = wb_dat_i;
    assign clint_bus.sel   = wb_sel_i;

    assign plic_bus.cyc    = wb_cyc_i;
    assign plic_bus.stb    = wb_stb_i & hit_plic;
    assign plic_bus.we     = wb_we_i;
    assign plic_bus.adr    = wb_adr_i[7:0];
    assign plic_bus.dat_w  = wb_dat_i;
    assign plic_bus.sel    = wb_sel_i;

    assign uart_bus.cyc    = wb_cyc_i;
    assign uart_bus.stb    = wb_stb_i & hit_uart;
    assign uart_bus.we     = wb_we_i;
    assign uart_bus.adr    = wb_adr_i[7:0];
    assign uart_bus.dat_w  = wb_dat_i;
    assign uart_bus.sel    = wb_sel_i;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Response return
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign wb_dat_o = hit_clint ? clint_bus.dat_r :
                      hit_plic  ? plic_bus.dat_r  :
                      hit_uart  ? uart_bus.dat_r  : '0;
    assign wb_ack_o = (hit_clint & clint_bus.ack) | (hit_plic & plic_bus.ack)
                    | (hit_uart & uart_bus.ack);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            err_q <= 1'b0;
        end else begin
            err_q <= wb_cyc_i & wb_stb_i & unmapped & ~err_q; // Same timing as ack.
        end
    end

    assign wb_err_o = err_q;

    a_one_slave: assert property (@(posedge clk) disable iff (!rst_n_i)
        $onehot0({clint_bus.stb, plic_bus.stb, uart_bus.stb}));
    a_ack_err: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(wb_ack_o && wb_err_o));
endmodule

/* logic/clint_timer.sv */
`timescale 1ns/100ps

module clint_timer (
    input  logic clk,
    input  logic rst_n_i,
    wb_if.slave  bus,
    output logic msip_o,
    output logic mtip_o
);
    import soc_pkg::*;

    localparam reg_off_t MSIP_OFF     = 8'h00;
    localparam reg_off_t MTIMECMP_OFF = 8'h04;
    localparam reg_off_t MTIME_OFF    = 8'h08;

    data_t mtime;
    data_t mtimecmp;
    data_t rd_data;
    logic  req;

    function automatic data_t merge_bytes(data_t old_v, data_t new_v, sel_t be);
        data_t res;
        res = old_v;
        for (int b = 0; b < $bits(sel_t); b++) begin
            if (be[b]) begin
                res[8*b +: 8] = new_v[8*b +: 8];
            end
        end
        return res;
    endfunction

    assign req = bus.cyc & bus.stb & ~bus.ack; // First cycle of an access.

    always_comb begin
        case (bus.adr)
            MSIP_OFF:     rd_data = data_t'(msip_o);
            MTIMECMP_OFF: rd_data = mtimecmp;
            MTIME_OFF:    rd_data = mtime;
            default:      rd_data = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            bus.ack  <= 1'b0;
            msip_o   <= 1'b0;
            mtip_o   <= 1'b0;
            mtime    <= '0;
            mtimecmp <= '1; // No timer interrupt until programmed.
        end else begin
            bus.ack <= req;
            mtip_o  <= (mtime >= mtimecmp);
            if (req && bus.we && bus.adr == MTIME_OFF) begin
                mtime <= merge_bytes(mtime, bus.dat_w, bus.sel);
            end else begin
                mtime <= mtime + 1'b1;
            end
            if (req && bus.we && bus.adr == MTIMECMP_OFF) begin
                mtimecmp <= merge_bytes(mtimecmp, bus.dat_w, bus.sel);
            end
            if (req && bus.we && bus.adr == MSIP_OFF && bus.sel[0]) begin
                msip_o <= bus.dat_w[0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req && !bus.we) begin
            bus.dat_r <= rd_data;
        end
    end

    a_ack_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
        bus.ack |=> !bus.ack);
endmodule

/* logic/plic_gateway.sv */
`timescale 1ns/100ps
`include "soc_params.svh"

module plic_gateway (
    input  logic              clk,
    input  logic              rst_n_i,
    wb_if.slave               bus,
    input  soc_pkg::irq_vec_t irq_src_i,
    output logic              meip_o
);
    import soc_pkg::*;

    irq_vec_t pending, enable, in_service;
    irq_id_t  claim_id;
    data_t    rd_data;
    logic     req, claim_rd, complete_wr;

    assign req         = bus.cyc & bus.stb & ~bus.ack;
    assign claim_rd    = req & ~bus.we & (bus.adr == 8'h08);
    assign complete_wr = req & bus.we & (bus.adr == 8'h08) & bus.sel[0];

    always_comb begin
        claim_id = '0;
        for (int i = `IRQ_NUM-1; i >= 0; i--) begin
            if (pending[i] && enable[i]) begin
                claim_id = irq_id_t'(i + 1); // Lowest index wins.
            end
        end
    end

    always_comb begin
        case (bus.adr)
            8'h00:   rd_data = data_t'(pending);
            8'h04:   rd_data = data_t'(enable);
            8'h08:   rd_data = data_t'(claim_id);
            default: rd_data = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            bus.ack    <= 1'b0;
            pending    <= '0;
            enable     <= '0;
            in_service <= '0;
            meip_o     <= 1'b0;
        end else begin
            bus.ack <= req;
            meip_o  <= |(pending & enable);
            if (req && bus.we && bus.adr == 8'h04 && bus.sel[0]) begin
                enable <= bus.dat_w[`IRQ_NUM-1:0];
            end
            for (int i = 0; i < `IRQ_NUM; i++) begin
                if (claim_rd && claim_id == irq_id_t'(i + 1)) begin
                    pending[i]    <= 1'b0;
                    in_service[i] <= 1'b1;
                end else begin
                    if (irq_src_i[i] && !in_service[i]) begin
                        pending[i] <= 1'b1; // Blocked while in service.
                    end
                    if (complete_wr && bus.dat_w[1:0] == irq_id_t'(i + 1)) begin
                        in_service[i] <= 1'b0;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req && !bus.we) begin
            bus.dat_r <= rd_data;
        end
    end

    a_pend_vs_serv: assert property (@(posedge clk) disable iff (!rst_n_i)
        (pending & in_service) == '0);
endmodule

/* logic/uart_core.sv */
`timescale 1ns/100ps

module uart_core (
    input  logic clk,
    input  logic rst_n_i,
    wb_if.slave  bus,
    input  logic rx_i,
    output logic tx_o,
    output logic irq_o
);
    import soc_pkg::*;

    uart_tx_state_e tx_state;
    uart_rx_state_e rx_state;
    baud_div_t      divisor, tx_cnt, rx_cnt;
    logic [2:0]     tx_bit, rx_bit;
    logic [7:0]     tx_data, rx_shift, rx_byte;
    logic [2:0]     rx_sync; // Two sync stages and one for edge detect.
    logic           rx_valid;
    logic           req, tx_start, data_rd;
    data_t          rd_data;

    assign req      = bus.cyc & bus.stb & ~bus.ack;
    assign tx_start = req & bus.we & (bus.adr == 8'h00) & bus.sel[0] & (tx_state == TX_IDLE);
    assign data_rd  = req & ~bus.we & (bus.adr == 8'h00);
    assign irq_o    = rx_valid;

    always_comb begin
        case (bus.adr)
            8'h00:   rd_data = data_t'(rx_byte);
            8'h04:   rd_data = data_t'({rx_valid, tx_state != TX_IDLE});
            8'h08:   rd_data = data_t'(divisor);
            default: rd_data = '0;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Registers and transmitter
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            bus.ack  <= 1'b0;
            divisor  <= 16'd15;
            tx_state <= TX_IDLE;
            tx_o     <= 1'b1;
            tx_cnt   <= '0;
            tx_bit   <= '0;
        end else begin
            bus.ack <= req;
            if (req && bus.we && bus.adr == 8'h08) begin
                if (bus.sel[0]) divisor[7:0] <= bus.dat_w[7:0];
                if (bus.sel[1]) divisor[15:8] <= bus.dat_w[15:8];
            end
            if (tx_state == TX_IDLE) begin
                if (tx_start) begin
                    tx_state <= TX_START;
                    tx_o     <= 1'b0; // Start bit.
                    tx_cnt   <= '0;
                end
            end else if (tx_cnt != divisor) begin
                tx_cnt <= tx_cnt + 1'b1;
            end else begin
                tx_cnt <= '0;
                case (tx_state)
                    TX_START: begin
                        tx_state <= TX_DATA;
                        tx_bit   <= '0;
                        tx_o     <= tx_data[0];
                    end
                    TX_DATA: begin
                        if (tx_bit == 3'd7) begin
                            tx_state <= TX_STOP;
                            tx_o     <= 1'b1;
                        end else begin
                            tx_bit <= tx_bit + 1'b1;
                            tx_o   <= tx_data[tx_bit + 3'd1]; // LSB first.
                        end
                    end
                    default: tx_state <= TX_IDLE;
                endcase
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Receiver
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rx_sync  <= '1;
            rx_state <= RX_IDLE;
            rx_cnt   <= '0;
            rx_bit   <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_sync <= {rx_sync[1:0], rx_i};
            if (data_rd) begin
                rx_valid <= 1'b0;
            end
            case (rx_state)
                RX_IDLE: begin
                    rx_cnt <= '0;
                    if (rx_sync[2] && !rx_sync[1]) rx_state <= RX_START; // Falling edge.
                end
                RX_START: begin
                    rx_cnt <= rx_cnt + 1'b1;
                    if (rx_cnt == (divisor >> 1)) begin
                        rx_cnt   <= '0;
                        rx_bit   <= '0;
                        rx_state <= rx_sync[1] ? RX_IDLE : RX_DATA; // Glitch check.
                    end
                end
                RX_DATA: begin
                    rx_cnt <= rx_cnt + 1'b1;
                    if (rx_cnt == divisor) begin
                        rx_cnt <= '0;
                        rx_bit <= rx_bit + 1'b1;
                        if (rx_bit == 3'd7) rx_state <= RX_STOP;
                    end
                end
                default: begin
                    rx_cnt <= rx_cnt + 1'b1;
                    if (rx_cnt == divisor) begin
                        rx_state <= RX_IDLE;
                        if (rx_sync[1]) rx_valid <= 1'b1; // Mid stop bit.
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (tx_start) tx_data <= bus.dat_w[7:0];
        if (req && !bus.we) bus.dat_r <= rd_data;
        if (rx_state == RX_DATA && rx_cnt == divisor) rx_shift <= {rx_sync[1], rx_shift[7:1]};
        if (rx_state == RX_STOP && rx_cnt == divisor && rx_sync[1]) rx_byte <= rx_shift;
    end

    a_tx_idle_high: assert property (@(posedge clk) disable iff (!rst_n_i)
        (tx_state == TX_IDLE) |-> tx_o);
endmodule

/* logic/periph_top.sv */
`timescale 1ns/100ps

module periph_top (
    input  logic           clk,
    input  logic           rst_n_i,
    input  logic           wb_cyc_i,
    input  logic           wb_stb_i,
    input  logic           wb_we_i,
    input  soc_pkg::addr_t wb_adr_i,
    input  soc_pkg::data_t wb_dat_i,
    input  soc_pkg::sel_t  wb_sel_i,
    output soc_pkg::data_t wb_dat_o,
    output logic           wb_ack_o,
    output logic           wb_err_o,
    input  logic           ext_irq_i,
    input  logic           rxd_i,
    output logic           txd_o,
    output logic           msip_o,
    output logic           mtip_o,
    output logic           meip_o
);
    import soc_pkg::*;

    logic     clint_rst_n, plic_rst_n, uart_rst_n;
    logic     uart_irq;
    irq_vec_t irq_src;

    wb_if clint_bus();
    wb_if plic_bus();
    wb_if uart_bus();

    // One synchronizer per slave; the decoder runs on the timer reset.
    rst_sync i_rst_clint (.clk(clk), .rst_n_i(rst_n_i), .rst_n_o(clint_rst_n));
    rst_sync i_rst_plic  (.clk(clk), .rst_n_i(rst_n_i), .rst_n_o(plic_rst_n));
    rst_sync i_rst_uart  (.clk(clk), .rst_n_i(rst_n_i), .rst_n_o(uart_rst_n));

    wb_decoder i_decoder (
        .clk(clk), .rst_n_i(clint_rst_n),
        .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i),
        .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i), .wb_sel_i(wb_sel_i),
        .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o), .wb_err_o(wb_err_o),
        .clint_bus(clint_bus.master), .plic_bus(plic_bus.master), .uart_bus(uart_bus.master)
    );

    clint_timer i_clint (
        .clk(clk), .rst_n_i(clint_rst_n), .bus(clint_bus.slave),
        .msip_o(msip_o), .mtip_o(mtip_o)
    );

    assign irq_src = {ext_irq_i, uart_irq}; // Source 0 is the UART.

    plic_gateway i_plic (
        .clk(clk), .rst_n_i(plic_rst_n), .bus(plic_bus.slave),
        .irq_src_i(irq_src), .meip_o(meip_o)
    );

    uart_core i_uart (
        .clk(clk), .rst_n_i(uart_rst_n), .bus(uart_bus.slave),
        .rx_i(rxd_i), .tx_o(txd_o), .irq_o(uart_irq)
    );
endmodule

/* verification/periph_tb.sv */
`timescale 1ns/100ps
`include "soc_params.svh"

module periph_tb;
    import soc_pkg::*;

    localparam int    CLK_PERIOD      = 100;
    localparam int    RESET_CYCLES    = 16;
    localparam int    WATCHDOG_CYCLES = 20000;
    localparam int    RSP_TIMEOUT     = 8;
    localparam int    POLL_LIMIT      = 200;
    localparam int    UART_BYTES      = 4;
    localparam addr_t CLINT_MSIP      = `CLINT_BASE + 16'h00;
    localparam addr_t CLINT_CMP       = `CLINT_BASE + 16'h04;
    localparam addr_t CLINT_MTIME     = `CLINT_BASE + 16'h08;
    localparam addr_t PLIC_ENABLE     = `PLIC_BASE + 16'h04;
    localparam addr_t PLIC_CLAIM      = `PLIC_BASE + 16'h08;
    localparam addr_t UART_DATA       = `UART_BASE + 16'h00;
    localparam addr_t UART_STAT       = `UART_BASE + 16'h04;

    logic  clk = 1'b0;
    logic  rst_n_i;
    logic  wb_cyc_i, wb_stb_i, wb_we_i;
    addr_t wb_adr_i;
    data_t wb_dat_i;
    sel_t  wb_sel_i;
    data_t wb_dat_o;
    logic  wb_ack_o, wb_err_o;
    logic  ext_irq_i, rxd_i, txd_o;
    logic  msip_o, mtip_o, meip_o;

    int          errors;
    int          n_access;
    integer      seed;
    int unsigned cycle_cnt = 0;
    int unsigned rsp_cycle;
    int unsigned mtip_edge;
    logic        armed, started, timer_on;
    logic        stb_q = 1'b0;
    logic        msip_ref = 1'b0;
    logic        rx_chk, stat_chk, claim_chk, meip_chk, meip_exp;
    logic [7:0]  rx_exp;
    data_t       claim_exp;
    addr_t       region;
    logic        mapped, rst_chk, mtip_exp;

    periph_top i_dut (
        .clk(clk), .rst_n_i(rst_n_i),
        .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i), .wb_adr_i(wb_adr_i),
        .wb_dat_i(wb_dat_i), .wb_sel_i(wb_sel_i), .wb_dat_o(wb_dat_o),
        .wb_ack_o(wb_ack_o), .wb_err_o(wb_err_o), .ext_irq_i(ext_irq_i),
        .rxd_i(rxd_i), .txd_o(txd_o), .msip_o(msip_o), .mtip_o(mtip_o), .meip_o(meip_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    assign rxd_i    = txd_o; // Serial loopback.
    assign region   = wb_adr_i & 16'hff00;
    assign mapped   = (region == `CLINT_BASE) || (region == `PLIC_BASE) || (region == `UART_BASE);
    assign rst_chk  = armed && !started;
    assign mtip_exp = timer_on && (cycle_cnt >= mtip_edge);

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        stb_q     <= wb_stb_i;
        if (wb_stb_i && !stb_q && wb_we_i && wb_adr_i == CLINT_MSIP && wb_sel_i[0]) begin
            msip_ref <= wb_dat_i[0]; // Bit 0 of the msip register.
        end
    end

    task automatic log_mismatch(input string name, input data_t exp_v, input data_t got_v);
        errors++;
        $display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp_v, got_v);
    endtask

    task automatic log_error(input string msg);
        errors++;
        $display("Error at %0t: %s", $time, msg);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    a_ack_timing: assert property (@(posedge clk) $rose(wb_stb_i) && mapped |=> wb_ack_o)
        else log_mismatch("wb_ack_o", 1, $sampled(wb_ack_o));
    a_err_timing: assert property (@(posedge clk)
        $rose(wb_stb_i) && !mapped |=> wb_err_o && !wb_ack_o)
        else log_mismatch("{wb_err_o,wb_ack_o}", 2'b10, $sampled({wb_err_o, wb_ack_o}));
    a_ack_single: assert property (@(posedge clk) wb_ack_o |=> !wb_ack_o)
        else log_mismatch("wb_ack_o", 0, $sampled(wb_ack_o));
    a_err_single: assert property (@(posedge clk) wb_err_o |=> !wb_err_o)
        else log_mismatch("wb_err_o", 0, $sampled(wb_err_o));
    a_rsp_req: assert property (@(posedge clk) (wb_ack_o || wb_err_o) |-> $past(wb_stb_i))
        else log_error("bus response seen without a pending request");
    a_rst_txd: assert property (@(posedge clk) rst_chk |-> txd_o)
        else log_mismatch("txd_o", 1, $sampled(txd_o));
    a_rst_outs: assert property (@(posedge clk)
        rst_chk |-> {wb_ack_o, wb_err_o, msip_o, mtip_o, meip_o} == 5'b0)
        else log_mismatch("{wb_ack_o,wb_err_o,msip_o,mtip_o,meip_o}", 0,
                          $sampled({wb_ack_o, wb_err_o, msip_o, mtip_o, meip_o}));
    a_msip: assert property (@(posedge clk) msip_o == msip_ref)
        else log_mismatch("msip_o", $sampled(msip_ref), $sampled(msip_o));
    a_mtip: assert property (@(posedge clk) mtip_o == mtip_exp)
        else log_mismatch("mtip_o", $sampled(mtip_exp), $sampled(mtip_o));
    a_rx_byte: assert property (@(posedge clk)
        rx_chk && wb_ack_o && !wb_we_i && wb_adr_i == UART_DATA |-> wb_dat_o[7:0] == rx_exp)
        else log_mismatch("wb_dat_o[7:0]", $sampled(rx_exp), $sampled(wb_dat_o[7:0]));
    a_rx_clear: assert property (@(posedge clk)
        stat_chk && wb_ack_o && !wb_we_i && wb_adr_i == UART_STAT |-> !wb_dat_o[1])
        else log_mismatch("wb_dat_o[1]", 0, $sampled(wb_dat_o[1]));
    a_claim: assert property (@(posedge clk)
        claim_chk && wb_ack_o && !wb_we_i && wb_adr_i == PLIC_CLAIM |-> wb_dat_o == claim_exp)
        else log_mismatch("wb_dat_o", $sampled(claim_exp), $sampled(wb_dat_o));
    a_meip: assert property (@(posedge clk) meip_chk |-> meip_o == meip_exp)
        else log_mismatch("meip_o", $sampled(meip_exp), $sampled(meip_o));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bus access
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic bus_cycle(input logic we, input addr_t adr, input data_t wdat,
                             output data_t rdat);
        int waited;
        @(posedge clk);
        #10;
        started  = 1'b1;
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = adr;
        wb_dat_i = wdat;
        wb_sel_i = '1;
        waited   = 0;
        n_access++;
        do begin
            @(negedge clk);
            waited++;
        end while (!wb_ack_o && !wb_err_o && waited < RSP_TIMEOUT);
        if (!wb_ack_o && !wb_err_o) begin
            log_error($sformatf("no bus response from address %h", adr));
        end
        rdat      = wb_dat_o;
        rsp_cycle = cycle_cnt;
        @(posedge clk);
        #10;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
    endtask

    task automatic wait_uart_status(input int bit_idx, input logic value);
        data_t st;
        int    polls;
        polls = 0;
        do begin
            bus_cycle(1'b0, UART_STAT, '0, st);
            polls++;
        end while (st[bit_idx] != value && polls < POLL_LIMIT);
        if (st[bit_idx] != value) begin
            log_error($sformatf("UART status bit %0d never reached %b", bit_idx, value));
        end
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Error at %0t: watchdog expired before the sequence ended", $time);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        data_t rd;
        data_t mtime_v;
        errors    = 0;
        n_access  = 0;
        seed      = 32'h667c;
        mtip_edge = 0;
        {armed, started, timer_on} = '0;
        {rx_chk, stat_chk, claim_chk, meip_chk, meip_exp} = '0;
        rx_exp    = '0;
        claim_exp = '0;
        rst_n_i   = 1'b0;
        {wb_cyc_i, wb_stb_i, wb_we_i} = '0;
        wb_adr_i  = '0;
        wb_dat_i  = '0;
        wb_sel_i  = '0;
        ext_irq_i = 1'b0;
        @(negedge clk);
        armed = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #10;
        rst_n_i = 1'b1;
        repeat (`RST_STAGES + 2) @(posedge clk);

        bus_cycle(1'b0, 16'h0300, '0, rd); // Unmapped regions.
        bus_cycle(1'b1, 16'hff04, 32'h1234, rd);

        bus_cycle(1'b1, CLINT_MSIP, 32'h1, rd);
        bus_cycle(1'b1, CLINT_MSIP, 32'h0, rd);
        bus_cycle(1'b0, CLINT_MTIME, '0, mtime_v);
        mtip_edge = rsp_cycle + 40;
        timer_on  = 1'b1;
        bus_cycle(1'b1, CLINT_CMP, mtime_v + 32'd40, rd);
        repeat (60) @(posedge clk);

        for (int n = 0; n < UART_BYTES; n++) begin
            rx_exp = 8'($random(seed));
            wait_uart_status(0, 1'b0);
            bus_cycle(1'b1, UART_DATA, data_t'(rx_exp), rd);
            wait_uart_status(1, 1'b1);
            rx_chk = 1'b1;
            bus_cycle(1'b0, UART_DATA, '0, rd);
            rx_chk   = 1'b0;
            stat_chk = 1'b1;
            bus_cycle(1'b0, UART_STAT, '0, rd);
            stat_chk = 1'b0;
        end

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // Interrupt claim and complete
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        bus_cycle(1'b1, PLIC_ENABLE, 32'h3, rd);
        @(posedge clk);
        #10;
        ext_irq_i = 1'b1;
        rx_exp    = 8'($random(seed));
        wait_uart_status(0, 1'b0);
        bus_cycle(1'b1, UART_DATA, data_t'(rx_exp), rd);
        wait_uart_status(1, 1'b1);
        meip_exp  = 1'b1;
        meip_chk  = 1'b1;
        claim_chk = 1'b1;
        claim_exp = 32'd1;
        bus_cycle(1'b0, PLIC_CLAIM, '0, rd);
        meip_chk  = 1'b0;
        claim_exp = 32'd2;
        bus_cycle(1'b0, PLIC_CLAIM, '0, rd);
        claim_exp = 32'd0; // Both sources in service.
        bus_cycle(1'b0, PLIC_CLAIM, '0, rd);
        claim_chk = 1'b0;
        @(posedge clk);
        #10;
        ext_irq_i = 1'b0;
        rx_chk    = 1'b1;
        bus_cycle(1'b0, UART_DATA, '0, rd);
        rx_chk = 1'b0;
        bus_cycle(1'b1, PLIC_CLAIM, 32'd1, rd);
        bus_cycle(1'b1, PLIC_CLAIM, 32'd2, rd);
        meip_exp = 1'b0;
        meip_chk = 1'b1;
        repeat (10) @(posedge clk);
        meip_chk = 1'b0;

        repeat (5) @(posedge clk);
        $display("Summary: %0d bus accesses, %0d errors", n_access, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end
endmodule

/* vlog.f */
+incdir+logic
logic/soc_pkg.sv
logic/wb_if.sv
logic/rst_sync.sv
logic/wb_decoder.sv
logic/clint_timer.sv
logic/plic_gateway.sv
logic/uart_core.sv
logic/periph_top.sv
verification/periph_tb.sv

/* run_verilator.sh */
#!/bin/sh
# Compiles the peripheral testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
    --top-module periph_tb -Mdir "$OBJ" -o periph_sim -f vlog.f
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

"./$OBJ/periph_sim" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -qx "TESTBENCH PASSED" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
